// File: vlog.f
logic/edge_write_pkg.sv
logic/edge_write_command_control.sv
logic/write_command_fifo.sv
logic/wb_write_master.sv
logic/edge_write_top.sv
verification/edge_write_properties.sv
verification/edge_write_tb.sv

// File: verification/edge_write_tb.sv
////////////////////
// Edge write path testbench
// Random results in, random-delay Wishbone slave out,
// every write checked against a model
////////////////////

`timescale 1ns/1ps

module edge_write_tb;

	localparam int WAIT_LIMIT = 2000;

	logic                          clock;
	logic                          rstn;
	logic                          enable;
	logic                          edge_valid;
	edge_write_pkg::edge_index_t   edge_index;
	edge_write_pkg::edge_data_t    edge_data;
	logic                          edge_ready;
	edge_write_pkg::config_word_t  config_word;
	logic                          base_valid;
	edge_write_pkg::bus_addr_t     base_address;
	logic                          wb_cyc;
	logic                          wb_stb;
	logic                          wb_we;
	edge_write_pkg::bus_addr_t     wb_adr;
	edge_write_pkg::line_data_t    wb_dat_w;
	edge_write_pkg::line_sel_t     wb_sel;
	edge_write_pkg::cmd_tag_t      wb_tga;
	logic                          wb_ack;

	int                            ack_delay = -1;
	bit                            saw_stall;
	edge_write_pkg::bus_addr_t     model_base;
	edge_write_pkg::config_word_t  model_cfg;
	edge_write_pkg::config_word_t  cfg;
	edge_write_pkg::bus_addr_t     exp_addr[$];
	edge_write_pkg::line_data_t    exp_line[$];
	edge_write_pkg::line_sel_t     exp_sel[$];
	edge_write_pkg::cmd_tag_t      exp_tag[$];

	edge_write_top #(.FIFO_DEPTH(8)) edge_write_top_inst (
		.clock (clock), .rstn (rstn), .enable (enable),
		.edge_valid (edge_valid), .edge_index (edge_index), .edge_data (edge_data),
		.edge_ready (edge_ready), .config_word (config_word),
		.base_valid (base_valid), .base_address (base_address),
		.wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_tga (wb_tga), .wb_ack (wb_ack)
	);

	always #20 clock = ~clock;

	task automatic fail_run();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_addr(input edge_write_pkg::bus_addr_t act, exp);
		if (act !== exp) begin
			$display("Error: wb_adr is %h, expected %h", act, exp);
			fail_run();
		end
	endtask

	task automatic check_line(input edge_write_pkg::line_data_t act, exp);
		if (act !== exp) begin
			$display("Error: wb_dat_w is %h, expected %h", act, exp);
			fail_run();
		end
	endtask

	task automatic check_sel(input edge_write_pkg::line_sel_t act, exp);
		if (act !== exp) begin
			$display("Error: wb_sel is %h, expected %h", act, exp);
			fail_run();
		end
	endtask

	task automatic check_tag(input edge_write_pkg::cmd_tag_t act, exp);
		if (act !== exp) begin
			$display("Error: wb_tga is %h, expected %h", act, exp);
			fail_run();
		end
	endtask

	task automatic check_flag(input string name, input logic act, exp);
		if (act !== exp) begin
			$display("Error: %s is %h, expected %h", name, act, exp);
			fail_run();
		end
	endtask

	// Reference model, one entry per accepted result
	function automatic void add_expected(input edge_write_pkg::edge_index_t idx,
		input edge_write_pkg::edge_data_t data);
		edge_write_pkg::bus_addr_t   byte_addr;
		edge_write_pkg::edge_data_t  swapped;
		edge_write_pkg::abort_code_t code;
		int                          lane;
		byte_addr = model_base + {idx, 2'b00};
		lane      = byte_addr[3:2];
		swapped   = {data[7:0], data[15:8], data[23:16], data[31:24]};
		code      = model_cfg[2:0];
		// Unknown codes become strict
		if (code > 3'd4) begin
			code = 3'd0;
		end
		exp_addr.push_back({byte_addr[31:4], 4'h0});
		exp_line.push_back(edge_write_pkg::line_data_t'(swapped) << (32 * lane));
		exp_sel.push_back(edge_write_pkg::line_sel_t'(4'hf) << (4 * lane));
		exp_tag.push_back({model_cfg[4], code});
	endfunction

	task automatic check_write();
		if (exp_addr.size() == 0) begin
			$display("A Wishbone write appeared with no result waiting for it");
			fail_run();
		end
		check_flag("wb_we", wb_we, 1'b1);
		check_addr(wb_adr, exp_addr.pop_front());
		check_line(wb_dat_w, exp_line.pop_front());
		check_sel(wb_sel, exp_sel.pop_front());
		check_tag(wb_tga, exp_tag.pop_front());
	endtask

	// Slave: ack after 0 to 6 extra cycles, one cycle wide
	always @(negedge clock) begin
		if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (rstn && wb_cyc) begin
			if (ack_delay < 0) begin
				ack_delay = $urandom_range(6, 0);
			end
			if (ack_delay == 0) begin
				check_write();
				wb_ack = 1'b1;
			end
			ack_delay = ack_delay - 1;
		end
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	task automatic send_edge(input edge_write_pkg::edge_index_t idx,
		input edge_write_pkg::edge_data_t data);
		int waited;
		waited = 0;
		@(negedge clock);
		edge_valid = 1'b1;
		edge_index = idx;
		edge_data  = data;
		while (!edge_ready) begin
			saw_stall = 1'b1;
			if (waited == WAIT_LIMIT) begin
				$display("edge_ready stayed low and the result was never taken");
				fail_run();
			end
			waited++;
			@(negedge clock);
		end
		// Transfers on the coming rising edge
		add_expected(idx, data);
	endtask

	task automatic send_burst(input int count, input bit gaps);
		for (int i = 0; i < count; i++) begin
			if (gaps && $urandom_range(1, 0) == 1) begin
				@(negedge clock);
				edge_valid = 1'b0;
			end
			send_edge(edge_write_pkg::edge_index_t'($urandom), $urandom);
		end
		@(negedge clock);
		edge_valid = 1'b0;
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (exp_addr.size() != 0 || wb_cyc) begin
			if (waited == WAIT_LIMIT) begin
				$display("Pending writes did not finish on the bus in time");
				fail_run();
			end
			waited++;
			@(negedge clock);
		end
	endtask

	task automatic load_base(input edge_write_pkg::bus_addr_t addr);
		@(negedge clock);
		base_valid   = 1'b1;
		base_address = addr;
		model_base   = addr;
		@(negedge clock);
		base_valid = 1'b0;
	endtask

	task automatic load_config(input edge_write_pkg::config_word_t word);
		@(negedge clock);
		config_word = word;
		if (word != '0) begin
			model_cfg = word;
		end
		@(negedge clock);
		config_word = '0;
	endtask

	initial begin
		void'($urandom(32'he3102fed));
		clock        = 1'b0;
		rstn         = 1'b0;
		enable       = 1'b0;
		edge_valid   = 1'b0;
		edge_index   = '0;
		edge_data    = '0;
		config_word  = '0;
		base_valid   = 1'b0;
		base_address = '0;
		wb_ack       = 1'b0;
		model_base   = '0;
		model_cfg    = '0;
		saw_stall    = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// Quiet bus after reset
		check_flag("wb_cyc", wb_cyc, 1'b0);
		check_flag("wb_stb", wb_stb, 1'b0);
		check_flag("edge_ready", edge_ready, 1'b0);
		enable = 1'b1;
		repeat (10) begin
			@(negedge clock);
			check_flag("wb_cyc", wb_cyc, 1'b0);
		end

		// Tag still zero from reset
		load_base($urandom);
		send_burst(20, 1'b1);
		wait_for_drain();

		// Abort codes 2, 3, then a zero word, then 5 to 7
		for (int round = 0; round < 6; round++) begin
			cfg      = $urandom;
			cfg[2:0] = 3'(round + 2);
			if (round == 2) begin
				cfg = '0;
			end
			load_config(cfg);
			load_base($urandom);
			send_burst(12, 1'b1);
			wait_for_drain();
		end

		// Back to back results against slow acks
		saw_stall = 1'b0;
		send_burst(60, 1'b0);
		wait_for_drain();
		if (!saw_stall) begin
			$display("edge_ready never fell while the FIFO was filling");
			fail_run();
		end

		// Enable low with writes in flight
		send_burst(6, 1'b0);
		enable = 1'b0;
		@(negedge clock);
		edge_valid = 1'b1;
		edge_index = edge_write_pkg::edge_index_t'($urandom);
		edge_data  = $urandom;
		repeat (20) begin
			check_flag("edge_ready", edge_ready, 1'b0);
			@(negedge clock);
		end
		edge_valid = 1'b0;
		wait_for_drain();
		enable = 1'b1;
		send_burst(10, 1'b1);
		wait_for_drain();

		// No stray write once every result is acked
		repeat (10) begin
			@(negedge clock);
			check_flag("wb_cyc", wb_cyc, 1'b0);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: verification/edge_write_properties.sv
////////////////////
// Wishbone master assertions
// Bound into the write master
////////////////////

`timescale 1ns/1ps

module edge_write_properties (
	input logic                          clock,
	input logic                          rstn,
	input logic                          not_empty,
	input logic                          cmd_pop,
	input logic                          wb_cyc,
	input logic                          wb_stb,
	input logic                          wb_we,
	input edge_write_pkg::bus_addr_t     wb_adr,
	input edge_write_pkg::line_data_t    wb_dat_w,
	input edge_write_pkg::line_sel_t     wb_sel,
	input edge_write_pkg::cmd_tag_t      wb_tga,
	input logic                          wb_ack
);

	stb_matches_cyc: assert property (@(posedge clock) disable iff (!rstn)
		wb_stb == wb_cyc)
		else $error("wb_stb does not follow wb_cyc");

	// Bus outputs frozen until the slave answers
	hold_until_ack: assert property (@(posedge clock) disable iff (!rstn)
		(wb_cyc && !wb_ack) |=> (wb_cyc && wb_we && $stable(wb_adr) && $stable(wb_dat_w)
			&& $stable(wb_sel) && $stable(wb_tga)))
		else $error("Wishbone outputs changed before ack");

	cyc_drops_after_ack: assert property (@(posedge clock) disable iff (!rstn)
		(wb_cyc && wb_ack) |=> !wb_cyc)
		else $error("wb_cyc still high after ack");

	pop_needs_data: assert property (@(posedge clock) disable iff (!rstn)
		cmd_pop |-> not_empty)
		else $error("Pop from an empty FIFO");

endmodule

bind wb_write_master edge_write_properties edge_write_properties_inst (
	.clock     (clock),
	.rstn      (rstn),
	.not_empty (not_empty),
	.cmd_pop   (cmd_pop),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_we     (wb_we),
	.wb_adr    (wb_adr),
	.wb_dat_w  (wb_dat_w),
	.wb_sel    (wb_sel),
	.wb_tga    (wb_tga),
	.wb_ack    (wb_ack)
);

// File: logic/edge_write_top.sv
////////////////////
// Edge write path top
// Producer, command FIFO and Wishbone master
////////////////////

`timescale 1ns/1ps

module edge_write_top #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,
	input  logic                         edge_valid,
	input  edge_write_pkg::edge_index_t  edge_index,
	input  edge_write_pkg::edge_data_t   edge_data,
	output logic                         edge_ready,
	input  edge_write_pkg::config_word_t config_word,
	input  logic                         base_valid,
	input  edge_write_pkg::bus_addr_t    base_address,
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output edge_write_pkg::bus_addr_t    wb_adr,
	output edge_write_pkg::line_data_t   wb_dat_w,
	output edge_write_pkg::line_sel_t    wb_sel,
	output edge_write_pkg::cmd_tag_t     wb_tga,
	input  logic                         wb_ack
);

	logic                          almost_full;
	logic                          cmd_push;
	edge_write_pkg::command_word_t cmd_word;
	logic                          cmd_pop;
	edge_write_pkg::command_word_t head_word;
	logic                          not_empty;

	edge_write_command_control edge_write_command_control_inst (
		.clock        (clock),
		.rstn         (rstn),
		.enable       (enable),
		.edge_valid   (edge_valid),
		.edge_index   (edge_index),
		.edge_data    (edge_data),
		.edge_ready   (edge_ready),
		.config_word  (config_word),
		.base_valid   (base_valid),
		.base_address (base_address),
		.almost_full  (almost_full),
		.cmd_push     (cmd_push),
		.cmd_word     (cmd_word)
	);

	write_command_fifo #(
		.DEPTH (FIFO_DEPTH),
		.WIDTH ($bits(edge_write_pkg::command_word_t))
	) write_command_fifo_inst (
		.clock       (clock),
		.rstn        (rstn),
		.cmd_push    (cmd_push),
		.cmd_word    (cmd_word),
		.cmd_pop     (cmd_pop),
		.head_word   (head_word),
		.not_empty   (not_empty),
		.almost_full (almost_full)
	);

	wb_write_master wb_write_master_inst (
		.clock     (clock),
		.rstn      (rstn),
		.not_empty (not_empty),
		.head_word (head_word),
		.cmd_pop   (cmd_pop),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_sel    (wb_sel),
		.wb_tga    (wb_tga),
		.wb_ack    (wb_ack)
	);

endmodule

// File: logic/wb_write_master.sv
////////////////////
// Wishbone classic write master
// One line-wide write cycle per command, idle gap in between
////////////////////

`timescale 1ns/1ps

module wb_write_master (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          not_empty,
	input  edge_write_pkg::command_word_t head_word,
	output logic                          cmd_pop,
	output logic                          wb_cyc,
	output logic                          wb_stb,
	output logic                          wb_we,
	output edge_write_pkg::bus_addr_t     wb_adr,
	output edge_write_pkg::line_data_t    wb_dat_w,
	output edge_write_pkg::line_sel_t     wb_sel,
	output edge_write_pkg::cmd_tag_t      wb_tga,
	input  logic                          wb_ack
);

	edge_write_pkg::master_state_e state;

	// Head is taken on the edge the cycle starts
	assign cmd_pop = (state == edge_write_pkg::MASTER_IDLE) && not_empty;

	////////////////////
	// Bus FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state  <= edge_write_pkg::MASTER_IDLE;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end else begin
			case (state)
				edge_write_pkg::MASTER_IDLE: begin
					if (not_empty) begin
						state  <= edge_write_pkg::MASTER_CYCLE;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we  <= 1'b1;
					end
				end
				edge_write_pkg::MASTER_CYCLE: begin
					// Hold everything until the slave acks
					if (wb_ack) begin
						state  <= edge_write_pkg::MASTER_GAP;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we  <= 1'b0;
					end
				end
				edge_write_pkg::MASTER_GAP: begin
					state <= edge_write_pkg::MASTER_IDLE;
				end
				default: begin
					state  <= edge_write_pkg::MASTER_IDLE;
					wb_cyc <= 1'b0;
					wb_stb <= 1'b0;
					wb_we  <= 1'b0;
				end
			endcase
		end
	end

	// Unpack the head word into the bus registers
	always_ff @(posedge clock) begin
		if (cmd_pop) begin
			wb_adr   <= head_word[edge_write_pkg::CMD_ADDR_LSB +: edge_write_pkg::ADDR_BITS];
			wb_dat_w <= head_word[edge_write_pkg::CMD_DATA_LSB +: edge_write_pkg::LINE_BITS];
			wb_sel   <= head_word[edge_write_pkg::CMD_SEL_LSB +: edge_write_pkg::LINE_BYTES];
			wb_tga   <= head_word[edge_write_pkg::CMD_TAG_LSB +: edge_write_pkg::TAG_BITS];
		end
	end

endmodule

// File: logic/write_command_fifo.sv
////////////////////
// Command FIFO
// Circular buffer of command words, almost full with under 3 slots free
////////////////////

`timescale 1ns/1ps

module write_command_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = $bits(edge_write_pkg::command_word_t)
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             cmd_push,
	input  logic [WIDTH-1:0] cmd_word,
	input  logic             cmd_pop,
	output logic [WIDTH-1:0] head_word,
	output logic             not_empty,
	output logic             almost_full
);

	localparam int PTR_BITS   = $clog2(DEPTH);
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	// Two results may still be on their way after almost_full rises
	localparam logic [COUNT_BITS-1:0] AF_LEVEL   = COUNT_BITS'(DEPTH - 2);
	localparam logic [COUNT_BITS-1:0] FULL_LEVEL = COUNT_BITS'(DEPTH);
	localparam logic [PTR_BITS-1:0]   LAST_SLOT  = PTR_BITS'(DEPTH - 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full        = (count == FULL_LEVEL);
	assign not_empty   = (count != '0);
	assign almost_full = (count >= AF_LEVEL);
	assign do_push     = cmd_push & ~full;
	assign do_pop      = cmd_pop & not_empty;
	assign head_word   = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= cmd_word;
		end
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/edge_write_command_control.sv
////////////////////
// Edge write command producer
// Takes edge results and builds line write commands
// with address, lane data, byte selects and tag
////////////////////

`timescale 1ns/1ps

module edge_write_command_control (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enable,
	input  logic                          edge_valid,
	input  edge_write_pkg::edge_index_t   edge_index,
	input  edge_write_pkg::edge_data_t    edge_data,
	output logic                          edge_ready,
	input  edge_write_pkg::config_word_t  config_word,
	input  logic                          base_valid,
	input  edge_write_pkg::bus_addr_t     base_address,
	input  logic                          almost_full,
	output logic                          cmd_push,
	output edge_write_pkg::command_word_t cmd_word
);

	localparam int WORD_SHIFT = $clog2(edge_write_pkg::DATA_BYTES);
	localparam int LANE_BITS  = $clog2(edge_write_pkg::LINE_LANES);

	logic                          enabled;
	logic                          edge_accept;
	edge_write_pkg::config_word_t  config_kept;
	edge_write_pkg::bus_addr_t     base_kept;
	logic                          in_valid;
	edge_write_pkg::edge_index_t   in_index;
	edge_write_pkg::edge_data_t    in_data;
	edge_write_pkg::bus_addr_t     byte_addr;
	edge_write_pkg::bus_addr_t     line_addr;
	logic [LANE_BITS-1:0]          lane;
	edge_write_pkg::line_data_t    line_data;
	edge_write_pkg::line_sel_t     line_sel;
	edge_write_pkg::abort_code_t   abort_code;
	edge_write_pkg::cmd_tag_t      tag;
	edge_write_pkg::command_word_t cmd_next;

	// Byte order reversal of one data word
	function automatic edge_write_pkg::edge_data_t swap_bytes(
		input edge_write_pkg::edge_data_t word
	);
		edge_write_pkg::edge_data_t swapped;
		for (int b = 0; b < edge_write_pkg::DATA_BYTES; b++) begin
			swapped[8*b +: 8] = word[8*(edge_write_pkg::DATA_BYTES-1-b) +: 8];
		end
		return swapped;
	endfunction

	////////////////////
	// Enable, configuration and base
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			config_kept <= '0;
			base_kept   <= '0;
		end else begin
			enabled <= enable;
			// Zero config words leave the kept value alone
			if (enabled && (|config_word)) begin
				config_kept <= config_word;
			end
			if (base_valid) begin
				base_kept <= base_address;
			end
		end
	end

	// Two slots in flight need room in the FIFO
	assign edge_ready  = enabled & ~almost_full;
	assign edge_accept = edge_valid & edge_ready;

	////////////////////
	// Input stage
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= edge_accept;
		end
	end

	always_ff @(posedge clock) begin
		if (edge_accept) begin
			in_index <= edge_index;
			in_data  <= edge_data;
		end
	end

	// Address, lane and tag
	always_comb begin
		byte_addr  = base_kept + (edge_write_pkg::bus_addr_t'(in_index) << WORD_SHIFT);
		line_addr  = byte_addr & ~edge_write_pkg::bus_addr_t'(edge_write_pkg::LINE_BYTES - 1);
		lane       = byte_addr[WORD_SHIFT +: LANE_BITS];
		abort_code = edge_write_pkg::map_abort_code(
			config_kept[edge_write_pkg::CFG_ABORT_LSB +: edge_write_pkg::ABORT_BITS]);
		tag        = {config_kept[edge_write_pkg::CFG_WRITE_MS_BIT], abort_code};
	end

	// Word lands in its lane, other lanes stay zero
	always_comb begin
		line_data = '0;
		line_sel  = '0;
		line_data[lane*edge_write_pkg::DATA_BITS +: edge_write_pkg::DATA_BITS] =
			swap_bytes(in_data);
		line_sel[lane*edge_write_pkg::DATA_BYTES +: edge_write_pkg::DATA_BYTES] = '1;
	end

	always_comb begin
		cmd_next = '0;
		cmd_next[edge_write_pkg::CMD_TAG_LSB +: edge_write_pkg::TAG_BITS]     = tag;
		cmd_next[edge_write_pkg::CMD_SEL_LSB +: edge_write_pkg::LINE_BYTES]   = line_sel;
		cmd_next[edge_write_pkg::CMD_DATA_LSB +: edge_write_pkg::LINE_BITS]   = line_data;
		cmd_next[edge_write_pkg::CMD_ADDR_LSB +: edge_write_pkg::ADDR_BITS]   = line_addr;
	end

	////////////////////
	// Command stage
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_push <= 1'b0;
		end else begin
			cmd_push <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			cmd_word <= cmd_next;
		end
	end

endmodule

// File: logic/edge_write_pkg.sv
////////////////////
// Edge write path package
// Widths, types, command word layout and the abort code rule
////////////////////

package edge_write_pkg;

	// Sizes in bytes
	localparam int DATA_BYTES = 4;
	localparam int LINE_BYTES = 16;
	localparam int LINE_LANES = LINE_BYTES / DATA_BYTES;

	// Field widths
	localparam int INDEX_BITS  = 24;
	localparam int DATA_BITS   = DATA_BYTES * 8;
	localparam int ADDR_BITS   = 32;
	localparam int LINE_BITS   = LINE_BYTES * 8;
	localparam int ABORT_BITS  = 3;
	localparam int TAG_BITS    = ABORT_BITS + 1;
	localparam int CONFIG_BITS = 32;

	typedef logic [INDEX_BITS-1:0]  edge_index_t;
	typedef logic [DATA_BITS-1:0]   edge_data_t;
	typedef logic [ADDR_BITS-1:0]   bus_addr_t;
	typedef logic [LINE_BITS-1:0]   line_data_t;
	typedef logic [LINE_BYTES-1:0]  line_sel_t;
	typedef logic [ABORT_BITS-1:0]  abort_code_t;
	typedef logic [TAG_BITS-1:0]    cmd_tag_t;
	typedef logic [CONFIG_BITS-1:0] config_word_t;

	// Configuration word fields
	localparam int CFG_ABORT_LSB    = 0;
	localparam int CFG_WRITE_MS_BIT = 4;

	// Tag is write_ms over the abort code
	localparam int TAG_WRITE_MS_BIT = TAG_BITS - 1;

	// Highest abort code passed through unchanged
	localparam abort_code_t ABORT_CODE_MAX = 3'd4;

	////////////////////
	// Command word layout, LSB first
	////////////////////
	localparam int CMD_TAG_LSB  = 0;
	localparam int CMD_SEL_LSB  = CMD_TAG_LSB + TAG_BITS;
	localparam int CMD_DATA_LSB = CMD_SEL_LSB + LINE_BYTES;
	localparam int CMD_ADDR_LSB = CMD_DATA_LSB + LINE_BITS;
	localparam int CMD_BITS     = CMD_ADDR_LSB + ADDR_BITS;

	typedef logic [CMD_BITS-1:0] command_word_t;

	// Consumer FSM states
	typedef enum logic [1:0] {
		MASTER_IDLE,
		MASTER_CYCLE,
		MASTER_GAP
	} master_state_e;

	// Unknown abort codes fall back to strict (0)
	function automatic abort_code_t map_abort_code(input abort_code_t code);
		abort_code_t mapped;
		if (code > ABORT_CODE_MAX) begin
			mapped = '0;
		end else begin
			mapped = code;
		end
		return mapped;
	endfunction

endpackage
